/* alu_cluster.f */
+incdir+.
alu_pkg.sv
alu_prf.sv
alu_exec.sv
alu_lane.sv
exec_ctrl.sv
alu_cluster.sv
tb_clock_gen.sv
alu_cluster_assertions.sv
alu_cluster_tb.sv

/* Bender.yml */
package:
  name: alu_cluster

sources:
  - include_dirs:
      - .
    files:
      - alu_pkg.sv
      - alu_prf.sv
      - alu_exec.sv
      - alu_lane.sv
      - exec_ctrl.sv
      - alu_cluster.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - alu_cluster_assertions.sv
      - alu_cluster_tb.sv

/* alu_cluster_tb.sv */
`timescale 1ns/1ns
`include "alu_cluster_cfg.svh"

module alu_cluster_tb;
    import alu_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_CYCLES = 4000;
    localparam int DRAIN      = 3;

    // expected outputs of one issue cycle, both lanes
    typedef struct packed {
        rob_finish_t [1:0] fin;
        prf_wr_t     [1:0] wr;
    } expect_t;

    logic               clk;
    logic               arst_n;
    logic               flush;
    logic        [1:0]  issue_valid;
    uop_bundle_t [1:0]  issue_uop;
    rob_finish_t [1:0]  rob_finish;
    prf_wr_t     [1:0]  wb_wr;

    word_t       model_rf [`ALU_PREG_NUM];
    expect_t     exp_q [$];    // entries i-3, i-2, i-1 while issuing i
    preg_t       recent [4];   // last destinations, for dependent sources
    logic [31:0] lcg_state = 32'd16;
    rob_id_t     next_rob = '0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(8)) u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    alu_cluster uut (.*);

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];  // low bits of the LCG are weak
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        return rand16() % n;
    endfunction

    function automatic word_t rand_word();
        logic [15:0] hi;
        hi = rand16();
        return {hi, rand16()};
    endfunction

    function automatic alu_type_e type_of(uop_e op);
        case (op)
            UOP_SLL, UOP_SLLV, UOP_SRL, UOP_SRLV, UOP_SRA, UOP_SRAV: return ALU_SHIFT;
            UOP_ADD, UOP_ADDI, UOP_ADDU, UOP_SUB, UOP_SUBU,
            UOP_SLT, UOP_SLTI, UOP_SLTU, UOP_SLTIU:                  return ALU_ARITH;
            UOP_MFHI, UOP_MTHI, UOP_MFLO, UOP_MTLO:                  return ALU_MOVE;
            UOP_CLZ, UOP_CLO:                                        return ALU_COUNT;
            default: return (op >= UOP_BEQ) ? ALU_BRANCH : ALU_LOGIC;
        endcase
    endfunction

    // second operand from a register rather than the immediate
    function automatic logic uses_rt(uop_e op);
        case (op)
            UOP_OR, UOP_AND, UOP_NOR, UOP_XOR, UOP_SLL, UOP_SLLV, UOP_SRL, UOP_SRLV,
            UOP_SRA, UOP_SRAV, UOP_ADD, UOP_ADDU, UOP_SUB, UOP_SUBU, UOP_SLT, UOP_SLTU,
            UOP_BEQ, UOP_BNE: return 1'b1;
            default:          return 1'b0;
        endcase
    endfunction

    function automatic logic writes_rd(uop_e op);
        case (op)
            UOP_NOP, UOP_BEQ, UOP_BNE, UOP_BGEZ, UOP_BGTZ, UOP_BLEZ, UOP_BLTZ,
            UOP_J, UOP_JR: return 1'b0;
            default:       return 1'b1;
        endcase
    endfunction

    function automatic word_t leading(word_t a, logic bit_val);
        word_t n;
        n = '0;
        for (int i = `ALU_XLEN - 1; i >= 0; i--) begin
            if (a[i] != bit_val) break;
            n++;
        end
        return n;
    endfunction

    function automatic preg_t pick_src();
        if (rand_below(4) != 0) return recent[rand_below(4)];
        return preg_t'(rand_below(`ALU_PREG_NUM));
    endfunction

    // value a new uop sees: prf with lane 1 winning, one-cycle bypass with lane 0 winning
    function automatic word_t read_reg(preg_t r);
        word_t v;
        int    l;
        v = model_rf[r];
        for (int e = 0; e < 3; e++) begin
            for (int k = 0; k < 2; k++) begin
                l = (e == 2) ? 1 - k : k;
                if (exp_q[e].wr[l].we && exp_q[e].wr[l].addr == r) v = exp_q[e].wr[l].data;
            end
        end
        return (r == '0) ? '0 : v;
    endfunction

    function automatic uop_bundle_t make_uop();
        uop_bundle_t u;
        u = '0;
        u.uop       = uop_e'(6'(rand_below(42)));
        u.alu_type  = type_of(u.uop);
        u.src0_addr = pick_src();
        u.src0_re   = 1'b1;
        u.src1_addr = pick_src();
        u.src1_re   = uses_rt(u.uop);
        u.dst_addr  = preg_t'(1 + rand_below(`ALU_PREG_NUM - 1));
        u.dst_we    = writes_rd(u.uop);
        case (rand_below(8))
            0:       u.imm = '0;
            1:       u.imm = '1;
            default: u.imm = rand_word();
        endcase
        if (u.uop == UOP_LUI) begin
            u.imm       = {rand16(), 16'h0};
            u.src0_addr = '0;
        end
        u.pc          = rand_word() & 32'hffff_fffc;
        u.branch_addr = rand_word() & 32'hffff_fffc;
        return u;
    endfunction

    function automatic void model_exec(input uop_bundle_t u, input word_t a, input word_t b,
                                       output word_t res, output logic ovf,
                                       output logic taken);
        logic [`ALU_XLEN:0] wide;
        res   = '0;
        ovf   = 1'b0;
        taken = 1'b0;
        case (u.uop)
            UOP_OR, UOP_ORI, UOP_LUI: res = a | b;
            UOP_AND, UOP_ANDI:        res = a & b;
            UOP_NOR:                  res = ~(a | b);
            UOP_XOR, UOP_XORI:        res = a ^ b;
            UOP_SLL:                  res = b << u.imm[4:0];
            UOP_SLLV:                 res = b << a[4:0];
            UOP_SRL:                  res = b >> u.imm[4:0];
            UOP_SRLV:                 res = b >> a[4:0];
            UOP_SRA:                  res = $signed(b) >>> u.imm[4:0];
            UOP_SRAV:                 res = $signed(b) >>> a[4:0];
            UOP_ADD, UOP_ADDI, UOP_ADDU, UOP_SUB, UOP_SUBU: begin
                if (u.uop == UOP_SUB || u.uop == UOP_SUBU) begin
                    wide = {a[31], a} - {b[31], b};
                end else begin
                    wide = {a[31], a} + {b[31], b};
                end
                res = wide[31:0];
                ovf = (u.uop != UOP_ADDU && u.uop != UOP_SUBU) && (wide[32] != wide[31]);
            end
            UOP_SLT, UOP_SLTI:        res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            UOP_SLTU, UOP_SLTIU:      res = (a < b) ? 32'd1 : 32'd0;
            UOP_MFHI, UOP_MTHI, UOP_MFLO, UOP_MTLO: res = a;
            UOP_CLZ:                  res = leading(a, 1'b0);
            UOP_CLO:                  res = leading(a, 1'b1);
            UOP_BEQ:                  taken = (a == b);
            UOP_BNE:                  taken = (a != b);
            UOP_BGEZ, UOP_BGEZAL:     taken = !a[31];
            UOP_BGTZ:                 taken = ($signed(a) > 0);
            UOP_BLEZ:                 taken = ($signed(a) <= 0);
            UOP_BLTZ, UOP_BLTZAL:     taken = a[31];
            UOP_J, UOP_JAL, UOP_JR, UOP_JALR: taken = 1'b1;
            default: ;
        endcase
        if (type_of(u.uop) == ALU_BRANCH) res = u.pc + 32'd8;  // link address
    endfunction

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_finish(input rob_finish_t act, input rob_finish_t exp, input int lane);
        string field;
        field = "";
        if (act.finish !== exp.finish) field = "finish";
        else if (exp.finish && act.rob_id !== exp.rob_id) field = "rob_id";
        else if (exp.finish && act.exception !== exp.exception) field = "exception";
        else if (exp.finish && act.branch_taken !== exp.branch_taken) field = "branch_taken";
        else if (exp.finish && act.branch_target !== exp.branch_target) field = "branch_target";
        if (field != "") begin
            $display("mismatch at %0t: lane %0d rob_finish.%s, got %h expected %h",
                     $time, lane, field, act, exp);
            stop_run();
        end
    endtask

    task automatic check_wr(input prf_wr_t act, input prf_wr_t exp, input int lane);
        string field;
        field = "";
        if (act.we !== exp.we) field = "we";
        else if (exp.we && act.addr !== exp.addr) field = "addr";
        else if (exp.we && act.data !== exp.data) field = "data";
        if (field != "") begin
            $display("mismatch at %0t: lane %0d wb_wr.%s, got %h expected %h",
                     $time, lane, field, act, exp);
            stop_run();
        end
    endtask

    initial begin
        #((NUM_CYCLES + DRAIN + 40) * CLK_PERIOD);
        $display("watchdog expired before the test reached its end");
        stop_run();
    end

    initial begin
        expect_t     ex;
        uop_bundle_t u [2];
        word_t       a;
        word_t       b;
        word_t       res;
        logic        ovf;
        logic        taken;
        logic        do_flush;
        logic [1:0]  valid;

        flush       = 1'b0;
        issue_valid = '0;
        issue_uop   = '0;
        for (int r = 0; r < `ALU_PREG_NUM; r++) model_rf[r] = '0;
        for (int k = 0; k < 4; k++) recent[k] = preg_t'(k + 1);
        ex = '0;
        repeat (3) exp_q.push_back(ex);  // empty pipeline after reset

        wait (arst_n === 1'b1);
        repeat (2) @(posedge clk);

        for (int cyc = 0; cyc < NUM_CYCLES + DRAIN; cyc++) begin
            @(posedge clk);
            ex = '0;
            do_flush = (cyc < NUM_CYCLES) && (rand_below(32) == 0);
            for (int l = 0; l < 2; l++) begin
                u[l] = make_uop();
                u[l].rob_id = next_rob;
                valid[l] = (cyc < NUM_CYCLES) && (rand_below(8) != 0);
                if (valid[l]) next_rob++;
                a = read_reg(u[l].src0_addr);
                b = u[l].src1_re ? read_reg(u[l].src1_addr) : u[l].imm;
                model_exec(u[l], a, b, res, ovf, taken);
                ex.fin[l].finish        = valid[l] && (u[l].uop != UOP_NOP);
                ex.fin[l].rob_id        = u[l].rob_id;
                ex.fin[l].exception     = ovf;
                ex.fin[l].branch_taken  = taken;
                ex.fin[l].branch_target = (u[l].uop == UOP_JR || u[l].uop == UOP_JALR) ?
                                          a : u[l].branch_addr;
                ex.wr[l].we   = valid[l] && u[l].dst_we && !ovf;
                ex.wr[l].addr = u[l].dst_addr;
                ex.wr[l].data = res;
                if (ex.wr[l].we) begin
                    for (int k = 3; k > 0; k--) recent[k] = recent[k - 1];
                    recent[0] = u[l].dst_addr;
                end
            end
            flush        <= do_flush;
            issue_valid  <= valid;
            issue_uop[0] <= u[0];
            issue_uop[1] <= u[1];
            exp_q.push_back(ex);
            // flush kills this issue and the uops in read and execute
            if (do_flush) begin
                for (int k = 1; k < 4; k++) exp_q[k] = '0;
            end

            @(negedge clk);
            ex = exp_q.pop_front();
            for (int l = 0; l < 2; l++) begin
                if (ex.wr[l].we) model_rf[ex.wr[l].addr] = ex.wr[l].data;
            end
            for (int l = 0; l < 2; l++) begin
                check_finish(rob_finish[l], ex.fin[l], l);
                check_wr(wb_wr[l], ex.wr[l], l);
            end
            if (uut.u_assertions.fail_count != 0) begin
                $display("a bound assertion on the cluster failed");
                stop_run();
            end
        end

        if (uut.u_assertions.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("a bound assertion on the cluster failed");
            stop_run();
        end
    end

endmodule

/* alu_cluster_assertions.sv */
`timescale 1ns/1ns

module alu_cluster_assertions (
    input logic                         clk,
    input logic                         arst_n,
    input logic                         flush,
    input logic                  [1:0]  issue_valid,
    input alu_pkg::uop_bundle_t  [1:0]  issue_uop,
    input alu_pkg::rob_finish_t  [1:0]  rob_finish,
    input alu_pkg::prf_wr_t      [1:0]  wb_wr
);
    import alu_pkg::*;

    int unsigned fail_count = 0;
    logic [1:0]  started;

    for (genvar l = 0; l < 2; l++) begin : g_lane
        assign started[l] = issue_valid[l] && (issue_uop[l].uop != UOP_NOP) && !flush;

        no_zero_write: assert property (@(posedge clk) disable iff (!arst_n)
            wb_wr[l].we |-> (wb_wr[l].addr != '0))
            else begin
                $error("lane %0d wrote physical register zero", l);
                fail_count++;
            end

        // issue edge plus two more edges without flush
        fixed_latency: assert property (@(posedge clk) disable iff (!arst_n)
            ($past(started[l], 3) && !$past(flush, 2) && !$past(flush, 1))
                |-> rob_finish[l].finish)
            else begin
                $error("lane %0d finish did not follow issue by three cycles", l);
                fail_count++;
            end

        we_needs_finish: assert property (@(posedge clk) disable iff (!arst_n)
            wb_wr[l].we |-> rob_finish[l].finish)
            else begin
                $error("lane %0d write enable without finish pulse", l);
                fail_count++;
            end
    end

endmodule

bind alu_cluster alu_cluster_assertions u_assertions (.*);

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // release away from the active edge
    end

endmodule

/* alu_cluster.sv */
`timescale 1ns/1ns

module alu_cluster (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         flush,
    input  logic                  [1:0]  issue_valid,
    input  alu_pkg::uop_bundle_t  [1:0]  issue_uop,
    output alu_pkg::rob_finish_t  [1:0]  rob_finish,
    output alu_pkg::prf_wr_t      [1:0]  wb_wr
);
    import alu_pkg::*;

    preg_t     [3:0] prf_rd_addr;   // lane 0 on ports 0/1, lane 1 on 2/3
    word_t     [3:0] prf_rd_data;
    prf_rd_t   [1:0] lane_rd_data;
    exec_res_t [1:0] wb_res;

    assign lane_rd_data[0].src0_data = prf_rd_data[0];
    assign lane_rd_data[0].src1_data = prf_rd_data[1];
    assign lane_rd_data[1].src0_data = prf_rd_data[2];
    assign lane_rd_data[1].src1_data = prf_rd_data[3];

    alu_prf u_prf (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_addr (prf_rd_addr),
        .rd_data (prf_rd_data),
        .wr      (wb_wr)
    );

    alu_lane lane0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue_uop (issue_uop[0]),
        .rd_addr   (prf_rd_addr[1:0]),
        .rd_data   (lane_rd_data[0]),
        .bypass    (wb_wr),
        .wb_res    (wb_res[0])
    );

    alu_lane lane1 (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue_uop (issue_uop[1]),
        .rd_addr   (prf_rd_addr[3:2]),
        .rd_data   (lane_rd_data[1]),
        .bypass    (wb_wr),
        .wb_res    (wb_res[1])
    );

    exec_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .wb_res      (wb_res),
        .wb_wr       (wb_wr),
        .rob_finish  (rob_finish)
    );

endmodule

/* exec_ctrl.sv */
`timescale 1ns/1ns

module exec_ctrl (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         flush,
    input  logic                  [1:0]  issue_valid,
    input  alu_pkg::exec_res_t    [1:0]  wb_res,
    output alu_pkg::prf_wr_t      [1:0]  wb_wr,
    output alu_pkg::rob_finish_t  [1:0]  rob_finish
);
    import alu_pkg::*;

    logic [1:0] rd_valid;
    logic [1:0] ex_valid;
    logic [1:0] wb_valid;
    logic [1:0] kill_n;

    assign kill_n = {2{~flush}};

    // flush kills read and execute, writeback still retires
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= '0;
            ex_valid <= '0;
            wb_valid <= '0;
        end else begin
            rd_valid <= issue_valid & kill_n;
            ex_valid <= rd_valid & kill_n;
            wb_valid <= ex_valid & kill_n;
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            wb_wr[l].we   = wb_valid[l] && wb_res[l].bundle.dst_we && !wb_res[l].overflow;
            wb_wr[l].addr = wb_res[l].bundle.dst_addr;
            wb_wr[l].data = wb_res[l].result;

            rob_finish[l].finish        = wb_valid[l] && (wb_res[l].bundle.uop != UOP_NOP);
            rob_finish[l].rob_id        = wb_res[l].bundle.rob_id;
            rob_finish[l].exception     = wb_res[l].overflow;
            rob_finish[l].branch_taken  = wb_res[l].bundle.branch_taken;
            rob_finish[l].branch_target = wb_res[l].bundle.branch_addr;
        end
    end

endmodule

/* alu_lane.sv */
`timescale 1ns/1ns

module alu_lane (
    input  logic                     clk,
    input  logic                     arst_n,
    input  alu_pkg::uop_bundle_t     issue_uop,
    output alu_pkg::preg_t    [1:0]  rd_addr,
    input  alu_pkg::prf_rd_t         rd_data,
    input  alu_pkg::prf_wr_t  [1:0]  bypass,
    output alu_pkg::exec_res_t       wb_res
);
    import alu_pkg::*;

    uop_bundle_t rd_uop;
    uop_bundle_t ex_uop;
    prf_rd_t     ex_rdata;
    exec_res_t   ex_res;

    // register read stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_uop <= '0;
        end else begin
            rd_uop <= issue_uop;
        end
    end

    assign rd_addr[0] = rd_uop.src0_addr;
    assign rd_addr[1] = rd_uop.src1_addr;

    // execute stage, operands captured with the bundle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_uop   <= '0;
            ex_rdata <= '0;
        end else begin
            ex_uop   <= rd_uop;
            ex_rdata <= rd_data;
        end
    end

    alu_exec u_exec (
        .uop    (ex_uop),
        .rdata  (ex_rdata),
        .bypass (bypass),
        .res    (ex_res)
    );

    // writeback stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_res <= '0;
        end else begin
            wb_res <= ex_res;
        end
    end

endmodule

/* alu_exec.sv */
`timescale 1ns/1ns
`include "alu_cluster_cfg.svh"

module alu_exec (
    input  alu_pkg::uop_bundle_t     uop,
    input  alu_pkg::prf_rd_t         rdata,
    input  alu_pkg::prf_wr_t  [1:0]  bypass,
    output alu_pkg::exec_res_t       res
);
    import alu_pkg::*;

    localparam int XLEN = `ALU_XLEN;
    localparam int CNT_W = $clog2(XLEN) + 1;

    uop_e           op;
    word_t          src0;
    word_t          src1;
    logic [1:0]     hit0;
    logic [1:0]     hit1;
    word_t          logic_res;
    word_t          shift_res;
    word_t          arith_res;
    word_t          move_res;
    word_t          count_res;
    word_t          branch_res;
    logic [4:0]     shamt;
    logic           is_sub;
    word_t          addend;
    logic [XLEN:0]  sum;
    logic           lt_signed;
    logic           lt_unsigned;
    logic           is_slt;
    logic           lead_bit;
    logic           lead_run;
    logic [CNT_W-1:0] lead_cnt;
    logic           taken;
    word_t          target;
    word_t          result;

    assign op = uop.uop;

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            hit0[b] = bypass[b].we && (bypass[b].addr == uop.src0_addr);
            hit1[b] = bypass[b].we && (bypass[b].addr == uop.src1_addr);
        end
    end

    // lane 0 writeback first, then lane 1, then register file
    assign src0 = !uop.src0_re ? rdata.src0_data :
                  hit0[0]      ? bypass[0].data  :
                  hit0[1]      ? bypass[1].data  : rdata.src0_data;
    assign src1 = !uop.src1_re ? uop.imm         :
                  hit1[0]      ? bypass[0].data  :
                  hit1[1]      ? bypass[1].data  : rdata.src1_data;

    always_comb begin
        case (op)
            UOP_OR, UOP_ORI, UOP_LUI: logic_res = src0 | src1;  // LUI imm pre-shifted
            UOP_AND, UOP_ANDI:        logic_res = src0 & src1;
            UOP_NOR:                  logic_res = ~(src0 | src1);
            UOP_XOR, UOP_XORI:        logic_res = src0 ^ src1;
            default:                  logic_res = '0;
        endcase
    end

    // fixed-amount shifts carry shamt in the immediate, value in src1
    assign shamt = (op == UOP_SLL || op == UOP_SRL || op == UOP_SRA) ? uop.imm[4:0] :
                   src0[4:0];

    always_comb begin
        case (op)
            UOP_SLL, UOP_SLLV: shift_res = src1 << shamt;
            UOP_SRL, UOP_SRLV: shift_res = src1 >> shamt;
            UOP_SRA, UOP_SRAV: shift_res = $signed(src1) >>> shamt;
            default:           shift_res = '0;
        endcase
    end

    assign is_sub = (op == UOP_SUB) || (op == UOP_SUBU) || (op == UOP_SLT) ||
                    (op == UOP_SLTI) || (op == UOP_SLTU) || (op == UOP_SLTIU);
    assign is_slt = (op == UOP_SLT) || (op == UOP_SLTI) || (op == UOP_SLTU) ||
                    (op == UOP_SLTIU);
    assign addend = is_sub ? ~src1 : src1;
    assign sum = {1'b0, src0} + {1'b0, addend} + {{XLEN{1'b0}}, is_sub};

    assign lt_signed = (src0[XLEN-1] != src1[XLEN-1]) ? src0[XLEN-1] : sum[XLEN-1];
    assign lt_unsigned = ~sum[XLEN];  // no carry out means borrow

    always_comb begin
        if (is_slt) begin
            arith_res = '0;
            arith_res[0] = (op == UOP_SLT || op == UOP_SLTI) ? lt_signed : lt_unsigned;
        end else begin
            arith_res = sum[XLEN-1:0];
        end
    end

    assign move_res = src0;  // HI/LO renamed, source always in src0

    // CLO counts ones, CLZ counts zeros
    assign lead_bit = (op == UOP_CLO);

    always_comb begin
        lead_cnt = '0;
        lead_run = 1'b1;
        for (int i = XLEN - 1; i >= 0; i--) begin
            lead_run = lead_run && (src0[i] == lead_bit);
            lead_cnt = lead_cnt + CNT_W'(lead_run);
        end
    end

    assign count_res = word_t'(lead_cnt);

    always_comb begin
        case (op)
            UOP_BEQ:                taken = (src0 == src1);
            UOP_BNE:                taken = (src0 != src1);
            UOP_BGEZ, UOP_BGEZAL:   taken = ~src0[XLEN-1];
            UOP_BGTZ:               taken = ~src0[XLEN-1] && (src0 != '0);
            UOP_BLEZ:               taken = src0[XLEN-1] || (src0 == '0);
            UOP_BLTZ, UOP_BLTZAL:   taken = src0[XLEN-1];
            UOP_J, UOP_JAL,
            UOP_JR, UOP_JALR:       taken = 1'b1;
            default:                taken = 1'b0;
        endcase
    end

    assign target = (op == UOP_JR || op == UOP_JALR) ? src0 : uop.branch_addr;
    assign branch_res = uop.pc + word_t'(8);  // link past the delay slot

    always_comb begin
        case (uop.alu_type)
            ALU_LOGIC:  result = logic_res;
            ALU_SHIFT:  result = shift_res;
            ALU_ARITH:  result = arith_res;
            ALU_MOVE:   result = move_res;
            ALU_COUNT:  result = count_res;
            ALU_BRANCH: result = branch_res;
            default:    result = '0;
        endcase
    end

    always_comb begin
        res = '0;
        res.bundle = uop;
        res.bundle.branch_addr = target;
        res.bundle.branch_taken = taken;
        res.result = result;
        res.overflow = (op == UOP_ADD || op == UOP_ADDI || op == UOP_SUB) &&
                       (src0[XLEN-1] == addend[XLEN-1]) &&
                       (sum[XLEN-1] != src0[XLEN-1]);
    end

endmodule

/* alu_prf.sv */
`timescale 1ns/1ns
`include "alu_cluster_cfg.svh"

module alu_prf (
    input  logic                    clk,
    input  logic                    arst_n,
    input  alu_pkg::preg_t  [3:0]   rd_addr,
    output alu_pkg::word_t  [3:0]   rd_data,
    input  alu_pkg::prf_wr_t [1:0]  wr
);
    import alu_pkg::*;

    word_t regs [`ALU_PREG_NUM];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ALU_PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr[0].we && wr[0].addr != '0) begin
                regs[wr[0].addr] <= wr[0].data;
            end
            if (wr[1].we && wr[1].addr != '0) begin  // later assignment, lane 1 wins
                regs[wr[1].addr] <= wr[1].data;
            end
        end
    end

    // write-first, same priority as the array update
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rd_data[p] = regs[rd_addr[p]];
            if (wr[0].we && wr[0].addr == rd_addr[p]) begin
                rd_data[p] = wr[0].data;
            end
            if (wr[1].we && wr[1].addr == rd_addr[p]) begin
                rd_data[p] = wr[1].data;
            end
            if (rd_addr[p] == '0) begin
                rd_data[p] = '0;  // hardwired zero
            end
        end
    end

endmodule

/* alu_pkg.sv */
`include "alu_cluster_cfg.svh"

package alu_pkg;

    typedef logic [`ALU_XLEN-1:0]             word_t;
    typedef logic [$clog2(`ALU_PREG_NUM)-1:0] preg_t;
    typedef logic [`ALU_ROB_ID_W-1:0]         rob_id_t;

    // NOP must stay at zero, reset stage contents decode as NOP
    typedef enum logic [5:0] {
        UOP_NOP = 6'd0,
        UOP_OR, UOP_ORI, UOP_LUI, UOP_AND, UOP_ANDI, UOP_NOR, UOP_XOR, UOP_XORI,
        UOP_SLL, UOP_SLLV, UOP_SRL, UOP_SRLV, UOP_SRA, UOP_SRAV,
        UOP_ADD, UOP_ADDI, UOP_ADDU, UOP_SUB, UOP_SUBU,
        UOP_SLT, UOP_SLTI, UOP_SLTU, UOP_SLTIU,
        UOP_MFHI, UOP_MTHI, UOP_MFLO, UOP_MTLO,
        UOP_CLZ, UOP_CLO,
        UOP_BEQ, UOP_BNE, UOP_BGEZ, UOP_BGEZAL, UOP_BGTZ, UOP_BLEZ,
        UOP_BLTZ, UOP_BLTZAL, UOP_J, UOP_JAL, UOP_JR, UOP_JALR
    } uop_e;

    typedef enum logic [2:0] {
        ALU_LOGIC,
        ALU_SHIFT,
        ALU_ARITH,
        ALU_MOVE,
        ALU_COUNT,
        ALU_BRANCH
    } alu_type_e;

    typedef struct packed {
        uop_e      uop;
        alu_type_e alu_type;
        rob_id_t   rob_id;
        preg_t     src0_addr;
        logic      src0_re;
        preg_t     src1_addr;
        logic      src1_re;
        preg_t     dst_addr;
        logic      dst_we;
        word_t     imm;          // already extended by decode
        word_t     pc;
        word_t     branch_addr;
        logic      branch_taken;
    } uop_bundle_t;

    typedef struct packed {
        word_t src0_data;
        word_t src1_data;
    } prf_rd_t;

    typedef struct packed {
        logic  we;
        preg_t addr;
        word_t data;
    } prf_wr_t;

    typedef struct packed {
        uop_bundle_t bundle;   // branch fields resolved
        word_t       result;
        logic        overflow;
    } exec_res_t;

    typedef struct packed {
        logic    finish;
        rob_id_t rob_id;
        logic    exception;
        logic    branch_taken;
        word_t   branch_target;
    } rob_finish_t;

endpackage

/* alu_cluster_cfg.svh */
`ifndef ALU_CLUSTER_CFG_SVH
`define ALU_CLUSTER_CFG_SVH

// integer datapath width
`define ALU_XLEN 32

// physical registers behind the rename map
`define ALU_PREG_NUM 64

// reorder buffer holds 2**ALU_ROB_ID_W entries
`define ALU_ROB_ID_W 6

`endif
